/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int wordWidth = 32;
    localparam int memDepth = 1024;
    localparam int memAddrWidth = 10;
    localparam int specRegWidth = 4;
    localparam int immWidth = 20;

    localparam logic [wordWidth-1:0] dataAreaStart = 32'd512;
    localparam logic [wordWidth-1:0] maxNumber = '1;
    localparam logic [wordWidth-1:0] pcResetValue = 32'd1;

    localparam logic [3:0] pcRegister = 4'd15;
    localparam logic [3:0] spRegister = 4'd14;
    localparam logic [3:0] lrRegister = 4'd13;
    localparam logic [3:0] savedSpRegister = 4'd5;
    localparam logic [4:0] hiddenSpRegister = 5'd16;  // Privileged stack, not addressable

    typedef enum logic [3:0] {
        opAdd       = 4'd0,
        opSub       = 4'd1,
        opAnd       = 4'd2,
        opOr        = 4'd3,
        opAddi      = 4'd4,
        opLoad      = 4'd5,
        opStore     = 4'd6,
        opBrz       = 4'd7,
        opEnterPriv = 4'd8,
        opExitPriv  = 4'd9,
        opCpxr      = 4'd10,
        opHalt      = 4'd11
    } opcodeT;

    typedef enum logic [2:0] {
        ctrlNone        = 3'd0,
        ctrlWriteAlu    = 3'd1,
        ctrlWriteLoad   = 3'd3,
        ctrlEnterPriv   = 3'd4,
        ctrlExitPriv    = 3'd5,
        ctrlCopySpecial = 3'd6
    } bankCtrlT;

    typedef struct packed {
        opcodeT      opcode;
        logic [3:0]  rd;
        logic [3:0]  rsA;
        logic [3:0]  rsB;
        logic [15:0] spare;
    } rFormT;

    typedef struct packed {
        opcodeT                      opcode;
        logic [3:0]                  rd;
        logic [3:0]                  rsA;
        logic signed [immWidth-1:0]  imm;
    } iFormT;

    typedef union packed {
        rFormT r;
        iFormT i;
    } instrWordT;

    typedef struct packed {
        logic                    read;
        logic                    write;
        logic [memAddrWidth-1:0] addr;
        logic [wordWidth-1:0]    wdata;
    } memReqT;

    typedef struct packed {
        logic                 valid;
        logic [wordWidth-1:0] rdata;
    } memRspT;

    typedef struct packed {
        logic       commit;
        bankCtrlT   ctrl;
        logic [3:0] rd;
    } bankCmdT;

endpackage

`default_nettype wire

/* regBank.sv */
`timescale 1ns/1ns
`default_nettype none

module regBank (
    input  logic                                fast_clock,
    input  logic                                reset,
    input  cpuPkg::bankCmdT                     bankCmd,
    input  logic                                shouldBranch,
    input  logic [3:0]                          rsA,
    input  logic [3:0]                          rsB,
    input  logic [cpuPkg::wordWidth-1:0]        aluResult,
    input  logic [cpuPkg::wordWidth-1:0]        loadData,
    input  logic [cpuPkg::wordWidth-1:0]        nextPc,
    input  logic [cpuPkg::specRegWidth-1:0]     specialPins,
    output logic [cpuPkg::wordWidth-1:0]        readDataA,
    output logic [cpuPkg::wordWidth-1:0]        readDataB,
    output logic [cpuPkg::wordWidth-1:0]        currentPc,
    output logic [cpuPkg::wordWidth-1:0]        storeData
);
    import cpuPkg::*;

    logic [wordWidth-1:0] bank [0:16];
    logic rdWritable;

    assign rdWritable = bankCmd.rd != pcRegister && bankCmd.rd != spRegister;

    // Registered read ports, one cycle behind the index
    always_ff @(posedge fast_clock) begin
        readDataA <= bank[rsA];
        readDataB <= bank[rsB];
        currentPc <= bank[pcRegister];
        storeData <= bank[bankCmd.rd];
    end

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            bank[0] <= dataAreaStart;
            bank[spRegister] <= maxNumber;         // User stack
            bank[pcRegister] <= pcResetValue;
            bank[hiddenSpRegister] <= maxNumber;   // Privileged stack
        end else if (bankCmd.commit) begin
            bank[pcRegister] <= shouldBranch ? aluResult : nextPc;
            case (bankCmd.ctrl)
                ctrlWriteAlu: begin
                    if (rdWritable) begin
                        bank[bankCmd.rd] <= aluResult;
                    end
                end
                ctrlWriteLoad: begin
                    if (rdWritable) begin
                        bank[bankCmd.rd] <= loadData;
                    end
                end
                ctrlEnterPriv: begin
                    bank[savedSpRegister] <= bank[spRegister];   // Keep user SP
                    bank[lrRegister] <= nextPc;                  // Return address
                    bank[spRegister] <= bank[hiddenSpRegister];
                end
                ctrlExitPriv: begin
                    bank[hiddenSpRegister] <= bank[spRegister];
                    bank[spRegister] <= bank[savedSpRegister];   // Back to user SP
                end
                ctrlCopySpecial: begin
                    bank[bankCmd.rd] <= {{(wordWidth-specRegWidth){1'b0}}, specialPins};
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module sequencer (
    input  logic                             fast_clock,
    input  logic                             reset,
    input  logic                             run,
    input  cpuPkg::instrWordT                instr,
    input  logic                             instrValid,
    input  logic                             lsDone,
    output logic                             fetchStart,
    output logic                             lsStart,
    output logic                             lsWrite,
    output cpuPkg::bankCmdT                  bankCmd,
    output cpuPkg::opcodeT                   aluOp,
    output logic                             useImm,
    output logic [cpuPkg::wordWidth-1:0]     immediate,
    output logic [3:0]                       rsA,
    output logic [3:0]                       rsB,
    output logic                             halted
);
    import cpuPkg::*;

    typedef enum logic [2:0] {
        sIdle, sFetch, sWaitFetch, sDecode, sExec, sMem, sCommit, sHalted
    } stateT;

    stateT state;
    stateT nextState;
    opcodeT opcode;
    logic isMemOp;

    // Both forms share opcode, rd and rsA positions
    assign opcode = instr.r.opcode;
    assign isMemOp = opcode == opLoad || opcode == opStore;

    assign rsA = instr.r.rsA;
    assign rsB = instr.r.rsB;
    assign immediate = {{(wordWidth-immWidth){instr.i.imm[immWidth-1]}}, instr.i.imm};
    assign useImm = opcode == opAddi || isMemOp;
    assign aluOp = opcode;
    assign lsWrite = opcode == opStore;

    assign fetchStart = state == sFetch;
    assign lsStart = state == sExec && isMemOp;   // Address is ready in EXEC
    assign halted = state == sHalted;

    always_comb begin
        nextState = state;
        case (state)
            sIdle:      if (run) nextState = sFetch;
            sFetch:     nextState = sWaitFetch;
            sWaitFetch: if (instrValid) nextState = sDecode;
            sDecode:    nextState = opcode == opHalt ? sHalted : sExec;
            sExec:      nextState = isMemOp ? sMem : sCommit;
            sMem:       if (lsDone) nextState = sCommit;
            sCommit:    nextState = run ? sFetch : sIdle;
            default:    nextState = sHalted;   // Held until reset
        endcase
    end

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        bankCmd.commit = state == sCommit;
        bankCmd.rd = instr.r.rd;
        case (opcode)
            opAdd, opSub, opAnd, opOr, opAddi: bankCmd.ctrl = ctrlWriteAlu;
            opLoad:      bankCmd.ctrl = ctrlWriteLoad;
            opEnterPriv: bankCmd.ctrl = ctrlEnterPriv;
            opExitPriv:  bankCmd.ctrl = ctrlExitPriv;
            opCpxr:      bankCmd.ctrl = ctrlCopySpecial;
            default:     bankCmd.ctrl = ctrlNone;   // Store, branch, halt
        endcase
    end

endmodule

`default_nettype wire

/* aluUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
    input  cpuPkg::opcodeT                   aluOp,
    input  logic [cpuPkg::wordWidth-1:0]     operandA,
    input  logic [cpuPkg::wordWidth-1:0]     operandB,
    input  logic [cpuPkg::wordWidth-1:0]     immediate,
    input  logic                             useImm,
    input  logic [cpuPkg::wordWidth-1:0]     currentPc,
    output logic [cpuPkg::wordWidth-1:0]     result,
    output logic [cpuPkg::wordWidth-1:0]     nextPc,
    output logic                             shouldBranch
);
    import cpuPkg::*;

    logic [wordWidth-1:0] secondOperand;

    assign secondOperand = useImm ? immediate : operandB;
    assign nextPc = currentPc + 1'b1;
    assign shouldBranch = aluOp == opBrz && operandA == '0;

    always_comb begin
        case (aluOp)
            opSub:   result = operandA - secondOperand;
            opAnd:   result = operandA & secondOperand;
            opOr:    result = operandA | secondOperand;
            opBrz:   result = currentPc + immediate;   // Branch target
            default: result = operandA + secondOperand;  // Add, addi, load/store address
        endcase
    end

endmodule

`default_nettype wire

/* fetchUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
    input  logic                             fast_clock,
    input  logic                             reset,
    input  logic                             fetchStart,
    input  logic [cpuPkg::wordWidth-1:0]     pc,
    input  logic                             grant,
    input  cpuPkg::memRspT                   rsp,
    output cpuPkg::memReqT                   req,
    output cpuPkg::instrWordT                instr,
    output logic                             instrValid
);
    import cpuPkg::*;

    logic pending;

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (fetchStart) begin
            pending <= 1'b1;
        end else if (grant) begin
            pending <= 1'b0;
        end
    end

    // Address follows the PC, which settles after the previous commit
    assign req.read = pending;
    assign req.write = 1'b0;
    assign req.addr = pc[memAddrWidth-1:0];
    assign req.wdata = '0;

    always_ff @(posedge fast_clock) begin
        if (rsp.valid) begin
            instr <= rsp.rdata;
        end
    end

    assign instrValid = rsp.valid;

endmodule

`default_nettype wire

/* loadStoreUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module loadStoreUnit (
    input  logic                             fast_clock,
    input  logic                             reset,
    input  logic                             lsStart,
    input  logic                             lsWrite,
    input  logic [cpuPkg::wordWidth-1:0]     address,
    input  logic [cpuPkg::wordWidth-1:0]     storeData,
    input  logic                             grant,
    input  cpuPkg::memRspT                   rsp,
    output cpuPkg::memReqT                   req,
    output logic [cpuPkg::wordWidth-1:0]     loadData,
    output logic                             lsDone
);
    import cpuPkg::*;

    logic pending;
    logic isWrite;
    logic loadDone;
    logic [memAddrWidth-1:0] addrReg;
    logic [wordWidth-1:0] dataReg;

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            pending <= 1'b0;
            isWrite <= 1'b0;
            loadDone <= 1'b0;
        end else begin
            if (lsStart) begin
                pending <= 1'b1;
                isWrite <= lsWrite;
            end else if (grant) begin
                pending <= 1'b0;
            end
            loadDone <= rsp.valid && !isWrite;
        end
    end

    always_ff @(posedge fast_clock) begin
        if (lsStart) begin
            addrReg <= address[memAddrWidth-1:0];   // Word address
            dataReg <= storeData;
        end
        if (rsp.valid && !isWrite) begin
            loadData <= rsp.rdata;
        end
    end

    assign req.read = pending && !isWrite;
    assign req.write = pending && isWrite;
    assign req.addr = addrReg;
    assign req.wdata = dataReg;

    // Store ends with its response, load one cycle later with the data
    assign lsDone = (rsp.valid && isWrite) || loadDone;

endmodule

`default_nettype wire

/* memArbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module memArbiter (
    input  logic                             fast_clock,
    input  logic                             reset,
    input  cpuPkg::memReqT                   hostReq,
    input  cpuPkg::memReqT                   lsReq,
    input  cpuPkg::memReqT                   fetchReq,
    output cpuPkg::memReqT                   memReq,
    input  logic [cpuPkg::wordWidth-1:0]     memRdata,
    output logic                             hostGrant,
    output logic                             lsGrant,
    output logic                             fetchGrant,
    output cpuPkg::memRspT                   hostRsp,
    output cpuPkg::memRspT                   lsRsp,
    output cpuPkg::memRspT                   fetchRsp
);
    import cpuPkg::*;

    logic hostOwned;
    logic lsOwned;
    logic fetchOwned;

    // Fixed priority: host, load/store, fetch
    assign hostGrant = hostReq.read || hostReq.write;
    assign lsGrant = !hostGrant && (lsReq.read || lsReq.write);
    assign fetchGrant = !hostGrant && !lsGrant && (fetchReq.read || fetchReq.write);

    always_comb begin
        if (hostGrant) begin
            memReq = hostReq;
        end else if (lsGrant) begin
            memReq = lsReq;
        end else if (fetchGrant) begin
            memReq = fetchReq;
        end else begin
            memReq = '0;   // Idle memory
        end
    end

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            hostOwned <= 1'b0;
            lsOwned <= 1'b0;
            fetchOwned <= 1'b0;
        end else begin
            hostOwned <= hostGrant;
            lsOwned <= lsGrant;
            fetchOwned <= fetchGrant;
        end
    end

    assign hostRsp = '{valid: hostOwned, rdata: memRdata};
    assign lsRsp = '{valid: lsOwned, rdata: memRdata};
    assign fetchRsp = '{valid: fetchOwned, rdata: memRdata};

endmodule

`default_nettype wire

/* sharedMemory.sv */
`timescale 1ns/1ns
`default_nettype none

module sharedMemory (
    input  logic                             fast_clock,
    input  cpuPkg::memReqT                   req,
    output logic [cpuPkg::wordWidth-1:0]     rdata
);
    import cpuPkg::*;

    logic [wordWidth-1:0] mem [0:memDepth-1];

    always_ff @(posedge fast_clock) begin
        if (req.write) begin
            mem[req.addr] <= req.wdata;
        end
        if (req.read) begin
            rdata <= mem[req.addr];   // Registered read data
        end
    end

endmodule

`default_nettype wire

/* cpuTop.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuTop (
    input  logic                             fast_clock,
    input  logic                             reset,
    input  logic                             run,
    input  logic [cpuPkg::specRegWidth-1:0]  specialPins,
    input  cpuPkg::memReqT                   hostReq,
    output logic                             hostGrant,
    output cpuPkg::memRspT                   hostRsp,
    output logic                             halted
);
    import cpuPkg::*;

    bankCmdT bankCmd;
    opcodeT aluOp;
    instrWordT instr;
    memReqT fetchReq;
    memReqT lsReq;
    memReqT memReq;
    memRspT lsRsp;
    memRspT fetchRsp;
    logic [3:0] rsA;
    logic [3:0] rsB;
    logic [wordWidth-1:0] aluResult;
    logic [wordWidth-1:0] loadData;
    logic [wordWidth-1:0] nextPc;
    logic [wordWidth-1:0] readDataA;
    logic [wordWidth-1:0] readDataB;
    logic [wordWidth-1:0] currentPc;
    logic [wordWidth-1:0] storeData;
    logic [wordWidth-1:0] immediate;
    logic [wordWidth-1:0] memRdata;
    logic shouldBranch;
    logic instrValid;
    logic lsDone;
    logic fetchStart;
    logic lsStart;
    logic lsWrite;
    logic useImm;
    logic lsGrant;
    logic fetchGrant;

    sequencer i_sequencer (
        .fast_clock (fast_clock),
        .reset      (reset),
        .run        (run),
        .instr      (instr),
        .instrValid (instrValid),
        .lsDone     (lsDone),
        .fetchStart (fetchStart),
        .lsStart    (lsStart),
        .lsWrite    (lsWrite),
        .bankCmd    (bankCmd),
        .aluOp      (aluOp),
        .useImm     (useImm),
        .immediate  (immediate),
        .rsA        (rsA),
        .rsB        (rsB),
        .halted     (halted)
    );

    regBank i_regBank (
        .fast_clock   (fast_clock),
        .reset        (reset),
        .bankCmd      (bankCmd),
        .shouldBranch (shouldBranch),
        .rsA          (rsA),
        .rsB          (rsB),
        .aluResult    (aluResult),
        .loadData     (loadData),
        .nextPc       (nextPc),
        .specialPins  (specialPins),
        .readDataA    (readDataA),
        .readDataB    (readDataB),
        .currentPc    (currentPc),
        .storeData    (storeData)
    );

    aluUnit i_aluUnit (
        .aluOp        (aluOp),
        .operandA     (readDataA),
        .operandB     (readDataB),
        .immediate    (immediate),
        .useImm       (useImm),
        .currentPc    (currentPc),
        .result       (aluResult),
        .nextPc       (nextPc),
        .shouldBranch (shouldBranch)
    );

    fetchUnit i_fetchUnit (
        .fast_clock (fast_clock),
        .reset      (reset),
        .fetchStart (fetchStart),
        .pc         (currentPc),
        .grant      (fetchGrant),
        .rsp        (fetchRsp),
        .req        (fetchReq),
        .instr      (instr),
        .instrValid (instrValid)
    );

    loadStoreUnit i_loadStoreUnit (
        .fast_clock (fast_clock),
        .reset      (reset),
        .lsStart    (lsStart),
        .lsWrite    (lsWrite),
        .address    (aluResult),
        .storeData  (storeData),
        .grant      (lsGrant),
        .rsp        (lsRsp),
        .req        (lsReq),
        .loadData   (loadData),
        .lsDone     (lsDone)
    );

    memArbiter i_memArbiter (
        .fast_clock (fast_clock),
        .reset      (reset),
        .hostReq    (hostReq),
        .lsReq      (lsReq),
        .fetchReq   (fetchReq),
        .memReq     (memReq),
        .memRdata   (memRdata),
        .hostGrant  (hostGrant),
        .lsGrant    (lsGrant),
        .fetchGrant (fetchGrant),
        .hostRsp    (hostRsp),
        .lsRsp      (lsRsp),
        .fetchRsp   (fetchRsp)
    );

    sharedMemory i_sharedMemory (
        .fast_clock (fast_clock),
        .req        (memReq),
        .rdata      (memRdata)
    );

endmodule

`default_nettype wire

/* tbCpuTop.sv */
`timescale 1ns/1ns
`default_nettype none

module tbCpuTop;
    import cpuPkg::*;

    localparam int programBase = 1;                  // First instruction address
    localparam int dataBase = int'(dataAreaStart);   // R0 after reset
    localparam logic [31:0] lfsrSeed = 32'h4d16ed73;

    // Word offsets from R0
    localparam logic [19:0] offA = 20'd0;
    localparam logic [19:0] offB = 20'd1;
    localparam logic [19:0] offAdd = 20'd16;
    localparam logic [19:0] offSub = 20'd17;
    localparam logic [19:0] offAnd = 20'd18;
    localparam logic [19:0] offOr = 20'd19;
    localparam logic [19:0] offAddi = 20'd20;
    localparam logic [19:0] offCopySrc = 20'd32;
    localparam logic [19:0] offCopyDst = 20'd33;
    localparam logic [19:0] offMarkSkip = 20'd40;
    localparam logic [19:0] offMarkRun = 20'd41;
    localparam logic [19:0] offPrivSp = 20'd48;
    localparam logic [19:0] offPrivLr = 20'd49;
    localparam logic [19:0] offUserSp = 20'd50;
    localparam logic [19:0] offPins = 20'd56;
    localparam logic [19:0] offGuardSp = 20'd60;
    localparam logic [19:0] offGuardPc = 20'd61;
    localparam int offHost = 100;                    // Written by the host during the run

    logic fast_clock = 1'b0;
    logic reset;
    logic run;
    logic [specRegWidth-1:0] specialPins;
    memReqT hostReq;
    logic hostGrant;
    memRspT hostRsp;
    logic halted;

    logic [31:0] lfsrState;
    logic [31:0] programWords [$];
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] immBits;
    logic [31:0] copySrc;
    logic [31:0] sentinel;
    logic [31:0] pinBits;
    logic [31:0] hostWords [4];
    int copyLoadAddr;
    int enterPrivAddr;
    int pcStoreAddr;
    int passCount = 0;
    int errorCount = 0;
    int cycleCount;
    int cycleLimit = 2000;

    cpuTop i_cpuTop (
        .fast_clock  (fast_clock),
        .reset       (reset),
        .run         (run),
        .specialPins (specialPins),
        .hostReq     (hostReq),
        .hostGrant   (hostGrant),
        .hostRsp     (hostRsp),
        .halted      (halted)
    );

    always #2 fast_clock = ~fast_clock;   // 4 ns period

    grantOneHot: assert property (@(posedge fast_clock) disable iff (reset)
        $onehot0({hostGrant, i_cpuTop.lsGrant, i_cpuTop.fetchGrant}))
    else begin
        errorCount++;
        $display("More than one memory grant in one cycle at %0t ns", $time);
    end

    hostAnswered: assert property (@(posedge fast_clock) disable iff (reset)
        hostGrant |=> hostRsp.valid)
    else begin
        errorCount++;
        $display("Host grant was not followed by a response at %0t ns", $time);
    end

    lsAnswered: assert property (@(posedge fast_clock) disable iff (reset)
        i_cpuTop.lsGrant |=> i_cpuTop.lsRsp.valid)
    else begin
        errorCount++;
        $display("Load/store grant was not followed by a response at %0t ns", $time);
    end

    fetchAnswered: assert property (@(posedge fast_clock) disable iff (reset)
        i_cpuTop.fetchGrant |=> i_cpuTop.fetchRsp.valid)
    else begin
        errorCount++;
        $display("Fetch grant was not followed by a response at %0t ns", $time);
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic randomBits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    function automatic logic [31:0] regForm(input opcodeT op, input logic [3:0] rd,
                                            input logic [3:0] rsA, input logic [3:0] rsB);
        instrWordT word;
        word.r.opcode = op;
        word.r.rd = rd;
        word.r.rsA = rsA;
        word.r.rsB = rsB;
        word.r.spare = '0;
        return word;
    endfunction

    function automatic logic [31:0] immForm(input opcodeT op, input logic [3:0] rd,
                                            input logic [3:0] rsA, input logic [19:0] imm);
        instrWordT word;
        word.i.opcode = op;
        word.i.rd = rd;
        word.i.rsA = rsA;
        word.i.imm = imm;
        return word;
    endfunction

    task automatic emit(input logic [31:0] word);
        programWords.push_back(word);
    endtask

    task automatic buildProgram();
        programWords.delete();
        emit(immForm(opLoad, 4'd1, 4'd0, offA));
        emit(immForm(opLoad, 4'd2, 4'd0, offB));
        emit(regForm(opAdd, 4'd3, 4'd1, 4'd2));
        emit(immForm(opStore, 4'd3, 4'd0, offAdd));
        emit(regForm(opSub, 4'd3, 4'd1, 4'd2));
        emit(immForm(opStore, 4'd3, 4'd0, offSub));
        emit(regForm(opAnd, 4'd3, 4'd1, 4'd2));
        emit(immForm(opStore, 4'd3, 4'd0, offAnd));
        emit(regForm(opOr, 4'd3, 4'd1, 4'd2));
        emit(immForm(opStore, 4'd3, 4'd0, offOr));
        emit(immForm(opAddi, 4'd3, 4'd1, immBits[19:0]));
        emit(immForm(opStore, 4'd3, 4'd0, offAddi));
        copyLoadAddr = programBase + programWords.size();
        emit(immForm(opLoad, 4'd4, 4'd0, offCopySrc));     // Word copy
        emit(immForm(opStore, 4'd4, 4'd0, offCopyDst));
        emit(regForm(opSub, 4'd6, 4'd0, 4'd0));             // R6 is zero
        emit(immForm(opBrz, 4'd0, 4'd6, 20'd2));            // Taken, skips the marker
        emit(immForm(opStore, 4'd1, 4'd0, offMarkSkip));
        emit(immForm(opBrz, 4'd0, 4'd0, 20'd2));            // R0 non-zero, falls through
        emit(immForm(opStore, 4'd2, 4'd0, offMarkRun));
        enterPrivAddr = programBase + programWords.size();
        emit(regForm(opEnterPriv, 4'd0, 4'd0, 4'd0));
        emit(immForm(opStore, 4'd14, 4'd0, offPrivSp));
        emit(immForm(opStore, 4'd13, 4'd0, offPrivLr));
        emit(regForm(opExitPriv, 4'd0, 4'd0, 4'd0));
        emit(immForm(opStore, 4'd14, 4'd0, offUserSp));
        emit(regForm(opCpxr, 4'd8, 4'd0, 4'd0));
        emit(immForm(opStore, 4'd8, 4'd0, offPins));
        emit(immForm(opAddi, 4'd14, 4'd0, 20'd5));          // Writes to SP and PC are refused
        emit(immForm(opAddi, 4'd15, 4'd0, 20'd100));
        emit(immForm(opLoad, 4'd14, 4'd0, offA));
        emit(immForm(opLoad, 4'd15, 4'd0, offB));
        emit(immForm(opStore, 4'd14, 4'd0, offGuardSp));
        pcStoreAddr = programBase + programWords.size();
        emit(immForm(opStore, 4'd15, 4'd0, offGuardPc));
        emit(regForm(opHalt, 4'd0, 4'd0, 4'd0));
    endtask

    task automatic hostWrite(input int addr, input logic [31:0] data);
        @(posedge fast_clock);
        #1;
        hostReq = '{read: 1'b0, write: 1'b1, addr: addr[memAddrWidth-1:0], wdata: data};
        @(negedge fast_clock);
        while (!hostGrant) @(negedge fast_clock);   // Held until granted
        @(posedge fast_clock);
        #1;
        hostReq = '0;
    endtask

    task automatic hostRead(input int addr, output logic [31:0] data);
        @(posedge fast_clock);
        #1;
        hostReq = '{read: 1'b1, write: 1'b0, addr: addr[memAddrWidth-1:0], wdata: '0};
        @(negedge fast_clock);
        while (!hostGrant) @(negedge fast_clock);
        @(posedge fast_clock);
        #1;
        hostReq = '0;
        @(negedge fast_clock);                      // Response one cycle after the grant
        assert (hostRsp.valid) else begin
            errorCount++;
            $display("Host read of address %0d returned no response", addr);
        end
        data = hostRsp.rdata;
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected) begin
            passCount++;
            $display("%-14s passed, value %h", name, actual);
        end else begin
            errorCount++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic readAndCheck(input string name, input int addr,
                                input logic [31:0] expected);
        logic [31:0] value;
        hostRead(addr, value);
        checkWord(name, expected, value);
    endtask

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge fast_clock);
            cycleCount++;
        end
        $display("Timeout, the run did not finish within %0d cycles", cycleLimit);
        $display("Test FAILED");
        $finish;
    end

    initial begin : mainFlow
        logic [31:0] resetFlags;
        reset = 1'b1;
        run = 1'b0;
        hostReq = '0;
        lfsrState = lfsrSeed;
        randomBits(32, opA);
        randomBits(32, opB);
        randomBits(20, immBits);
        randomBits(32, copySrc);
        randomBits(4, pinBits);
        for (int k = 0; k < 4; k++) begin
            randomBits(32, hostWords[k]);
        end
        sentinel = ~opA;                             // Never equal to the skipped store value
        specialPins = pinBits[specRegWidth-1:0];
        buildProgram();
        cycleLimit = 40 * programWords.size() + 2000;

        repeat (4) @(posedge fast_clock);
        #1 reset = 1'b0;
        @(negedge fast_clock);
        resetFlags = {25'b0, i_cpuTop.fetchStart, i_cpuTop.lsStart, i_cpuTop.bankCmd.commit,
                      hostGrant, i_cpuTop.lsGrant, i_cpuTop.fetchGrant, halted};
        checkWord("resetState", 32'h0, resetFlags);

        for (int k = 0; k < programWords.size(); k++) begin
            hostWrite(programBase + k, programWords[k]);
        end
        hostWrite(dataBase + int'(offA), opA);
        hostWrite(dataBase + int'(offB), opB);
        hostWrite(dataBase + int'(offCopySrc), copySrc);
        hostWrite(dataBase + int'(offMarkSkip), sentinel);
        hostWrite(dataBase + int'(offMarkRun), sentinel);

        @(posedge fast_clock);
        #1 run = 1'b1;
        // Copy load raises its memory request in the next cycle
        while (!(i_cpuTop.lsStart && i_cpuTop.currentPc == copyLoadAddr)) begin
            @(negedge fast_clock);
        end
        for (int k = 0; k < 4; k++) begin
            hostWrite(dataBase + offHost + k, hostWords[k]);   // Contends with the core
        end
        while (!halted) @(negedge fast_clock);
        @(posedge fast_clock);
        #1 run = 1'b0;

        readAndCheck("add", dataBase + int'(offAdd), opA + opB);
        readAndCheck("sub", dataBase + int'(offSub), opA - opB);
        readAndCheck("and", dataBase + int'(offAnd), opA & opB);
        readAndCheck("or", dataBase + int'(offOr), opA | opB);
        readAndCheck("addi", dataBase + int'(offAddi),
                     opA + {{12{immBits[19]}}, immBits[19:0]});
        readAndCheck("copy", dataBase + int'(offCopyDst), copySrc);
        for (int k = 0; k < 4; k++) begin
            readAndCheck($sformatf("hostWrite%0d", k), dataBase + offHost + k, hostWords[k]);
        end
        readAndCheck("brzTaken", dataBase + int'(offMarkSkip), sentinel);
        readAndCheck("brzNotTaken", dataBase + int'(offMarkRun), opB);
        readAndCheck("privSp", dataBase + int'(offPrivSp), maxNumber);
        readAndCheck("privReturn", dataBase + int'(offPrivLr), enterPrivAddr + 1);
        readAndCheck("userSp", dataBase + int'(offUserSp), maxNumber);
        readAndCheck("cpxr", dataBase + int'(offPins), {28'b0, pinBits[3:0]});
        readAndCheck("guardSp", dataBase + int'(offGuardSp), maxNumber);
        readAndCheck("guardPc", dataBase + int'(offGuardPc), pcStoreAddr);

        $display("Checks passed: %0d, failed: %0d", passCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
cpuPkg.sv
regBank.sv
sequencer.sv
aluUnit.sv
fetchUnit.sv
loadStoreUnit.sv
memArbiter.sv
sharedMemory.sv
cpuTop.sv
tbCpuTop.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tbCpuTop
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Test OK" $(LOG) && echo "Simulation passed" || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
